// File: verilog/elevator_settings.svh
/*
 * Build constants for the floor request controller
 * Floor count, field widths and the car state code boundary
 */

`ifndef ELEVATOR_SETTINGS_SVH
`define ELEVATOR_SETTINGS_SVH

// Number of floors served, also the depth of the request stack
`define FLOOR_COUNT 11

// Floor numbers run 0 to 10
`define FLOOR_BITS 4

// Width of the car FSM state code
`define STATE_BITS 6

// Codes 0 to 10 are the stopped states, one per floor
`define STOP_STATE_LAST 10

// Stack occupancy, 0 to 11
`define COUNT_BITS 4

`endif

// File: verilog/elevator_pkg.sv
/*
 * Shared packed struct types for the floor request controller
 * Button sets, car status, requests, dispatch word and served pulse
 */

`default_nettype none

package elevator_pkg;

`include "elevator_settings.svh"

    // One bit per floor, used for the buttons and for their lights
    typedef struct packed {
        logic [`FLOOR_COUNT-1:0] call;
        logic [`FLOOR_COUNT-1:0] panel;
    } button_set_t;

    // Status reported by the car motion FSM
    typedef struct packed {
        logic [`FLOOR_BITS-1:0] floor;
        logic [`STATE_BITS-1:0] state;
    } car_status_t;

    // One captured request
    typedef struct packed {
        logic [`FLOOR_BITS-1:0] floor;
        logic                   from_panel;
    } floor_req_t;

    // Command word towards the car FSM
    typedef struct packed {
        logic [`FLOOR_BITS-1:0] target;
        logic                   direction_up;
        logic                   activate;
    } dispatch_t;

    // Pulse for a request retired at its floor
    typedef struct packed {
        logic                   valid;
        logic [`FLOOR_BITS-1:0] floor;
    } served_t;

endpackage

`default_nettype wire

// File: verilog/request_capture.sv
/*
 * Button capture stage
 * Masks the buttons, picks one request per cycle and keeps the lights
 */

`timescale 1ns/1ps
`default_nettype none

`include "elevator_settings.svh"

module request_capture (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::button_set_t buttons,
    input  logic [`FLOOR_BITS-1:0]    current_floor,
    input  logic                      power_on,
    input  logic                      emergency,
    output logic                      push_valid,
    output elevator_pkg::floor_req_t  push_req,
    input  logic                      push_ready,
    input  elevator_pkg::served_t     served,
    output elevator_pkg::button_set_t lights
);

    logic                    active;
    logic [`FLOOR_COUNT-1:0] here_mask;
    logic [`FLOOR_COUNT-1:0] panel_open;
    logic [`FLOOR_COUNT-1:0] call_open;
    logic                    push_fire;

    // Index of the lowest set bit, scanning down so the lowest one is kept last
    function automatic logic [`FLOOR_BITS-1:0] lowest_set(
        input logic [`FLOOR_COUNT-1:0] vec
    );
        logic [`FLOOR_BITS-1:0] index;
        index = '0;
        for (int i = `FLOOR_COUNT - 1; i >= 0; i--) begin
            if (vec[i]) begin
                index = `FLOOR_BITS'(i);
            end
        end
        return index;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Request selection
    //////////////////////////////////////////////////////////////////////

    assign active    = power_on && !emergency;
    assign here_mask = `FLOOR_COUNT'(1) << current_floor;

    // Skip the floor the car stands at and anything already lit
    assign panel_open = buttons.panel & ~lights.panel & ~here_mask;
    assign call_open  = buttons.call & ~lights.call & ~here_mask;

    assign push_valid = active && ((|panel_open) || (|call_open));
    assign push_fire  = push_valid && push_ready;

    // Panel buttons win over hall calls
    always_comb begin
        push_req.from_panel = |panel_open;
        if (|panel_open) begin
            push_req.floor = lowest_set(panel_open);
        end else begin
            push_req.floor = lowest_set(call_open);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Button lights
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lights <= '0;
        end else if (!active) begin
            lights <= '0;
        end else begin
            if (served.valid) begin
                lights.call[served.floor]  <= 1'b0;
                lights.panel[served.floor] <= 1'b0;
            end
            // Set after the clear, so a push to the served floor keeps its light
            if (push_fire) begin
                if (push_req.from_panel) begin
                    lights.panel[push_req.floor] <= 1'b1;
                end else begin
                    lights.call[push_req.floor] <= 1'b1;
                end
            end
        end
    end

    lights_dark_after_power_off: assert property (
        @(posedge clock) disable iff (!reset_n)
        !power_on |=> (lights == '0)
    );

endmodule

`default_nettype wire

// File: verilog/floor_request_stack.sv
/*
 * Last-in first-out store of requested floors
 * Push and pop handshakes, occupancy counter and flush
 */

`timescale 1ns/1ps
`default_nettype none

`include "elevator_settings.svh"

module floor_request_stack (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     flush,
    input  logic                     push_valid,
    input  elevator_pkg::floor_req_t push_req,
    output logic                     push_ready,
    output logic                     top_valid,
    output logic [`FLOOR_BITS-1:0]   top_floor,
    input  logic                     pop_ready
);

    localparam logic [`COUNT_BITS-1:0] depth = `COUNT_BITS'(`FLOOR_COUNT);

    logic [`FLOOR_BITS-1:0] entries [`FLOOR_COUNT];
    logic [`COUNT_BITS-1:0] count;
    logic [`COUNT_BITS-1:0] top_index;
    logic                   push_fire;
    logic                   pop_fire;

    assign push_ready = (count != depth);
    assign top_valid  = (count != '0);
    assign top_index  = count - 1'b1;
    assign top_floor  = top_valid ? entries[top_index] : '0;

    // A flush cycle moves nothing in or out
    assign push_fire = push_valid && push_ready && !flush;
    assign pop_fire  = pop_ready && top_valid && !flush;

    //////////////////////////////////////////////////////////////////////
    // Occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else if (push_fire && !pop_fire) begin
            count <= count + 1'b1;
        end else if (pop_fire && !push_fire) begin
            count <= count - 1'b1;
        end
    end

    // Entry storage, a push with a pop overwrites the top in place
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `FLOOR_COUNT; i++) begin
                entries[i] <= '0;
            end
        end else if (push_fire) begin
            if (pop_fire) begin
                entries[top_index] <= push_req.floor;
            end else begin
                entries[count] <= push_req.floor;
            end
        end
    end

    count_in_range: assert property (
        @(posedge clock) disable iff (!reset_n)
        count <= depth
    );

    no_push_when_full: assert property (
        @(posedge clock) disable iff (!reset_n)
        push_valid && (count == depth) && !pop_fire && !flush |=> (count == depth)
    );

endmodule

`default_nettype wire

// File: verilog/dispatch_unit.sv
/*
 * Target selection for the car FSM
 * Direction, retiring of served requests and door permissions
 */

`timescale 1ns/1ps
`default_nettype none

`include "elevator_settings.svh"

module dispatch_unit (
    input  logic                      clock,
    input  elevator_pkg::car_status_t car,
    input  logic                      power_on,
    input  logic                      emergency,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    input  logic                      top_valid,
    input  logic [`FLOOR_BITS-1:0]    top_floor,
    output logic                      pop_ready,
    output elevator_pkg::dispatch_t   dispatch,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    logic stopped;
    logic go;

    // Stop codes sit below every moving and emergency code
    assign stopped = (car.state <= `STATE_BITS'(`STOP_STATE_LAST));
    assign go      = stopped && power_on && !emergency && top_valid;

    //////////////////////////////////////////////////////////////////////
    // Target and direction
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dispatch.activate = go;
        if (go) begin
            dispatch.target       = top_floor;
            dispatch.direction_up = (top_floor >= car.floor);
        end else begin
            dispatch.target       = car.floor;
            dispatch.direction_up = 1'b0;
        end
    end

    // Car has reached the newest request
    assign pop_ready = go && (car.floor == top_floor);

    // Doors only move with the car at rest and power present
    assign door_open_allowed  = stopped && power_on && door_open_button;
    assign door_close_allowed = stopped && power_on && door_close_button;

    target_is_a_floor: assert property (
        @(posedge clock)
        dispatch.activate |-> (dispatch.target < `FLOOR_BITS'(`FLOOR_COUNT))
    );

endmodule

`default_nettype wire

// File: verilog/floor_controller_top.sv
/*
 * Floor request controller top level
 * Capture stage, request stack and dispatch unit
 */

`timescale 1ns/1ps
`default_nettype none

`include "elevator_settings.svh"

module floor_controller_top (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::button_set_t buttons,
    input  elevator_pkg::car_status_t car,
    input  logic                      power_on,
    input  logic                      emergency,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    output elevator_pkg::dispatch_t   dispatch,
    output elevator_pkg::button_set_t lights,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    logic                     push_valid;
    elevator_pkg::floor_req_t push_req;
    logic                     push_ready;
    logic                     top_valid;
    logic [`FLOOR_BITS-1:0]   top_floor;
    logic                     pop_ready;
    logic                     flush;
    elevator_pkg::served_t    served;

    assign flush = !power_on || emergency;

    // Every pop is a served floor
    assign served.valid = top_valid && pop_ready;
    assign served.floor = top_floor;

    request_capture capture0 (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (buttons),
        .current_floor (car.floor),
        .power_on      (power_on),
        .emergency     (emergency),
        .push_valid    (push_valid),
        .push_req      (push_req),
        .push_ready    (push_ready),
        .served        (served),
        .lights        (lights)
    );

    floor_request_stack stack0 (
        .clock      (clock),
        .reset_n    (reset_n),
        .flush      (flush),
        .push_valid (push_valid),
        .push_req   (push_req),
        .push_ready (push_ready),
        .top_valid  (top_valid),
        .top_floor  (top_floor),
        .pop_ready  (pop_ready)
    );

    dispatch_unit dispatch0 (
        .clock              (clock),
        .car                (car),
        .power_on           (power_on),
        .emergency          (emergency),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .top_valid          (top_valid),
        .top_floor          (top_floor),
        .pop_ready          (pop_ready),
        .dispatch           (dispatch),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

`default_nettype wire

// File: tests/floor_controller_tb.sv
/*
 * Testbench for the floor request controller
 * Random buttons, a car model, a reference model and compare tasks
 */

`timescale 1ns/1ps
`default_nettype none

`include "elevator_settings.svh"

module floor_controller_tb;

    localparam int clock_period = 8;
    localparam int reset_cycles = 16;
    localparam int test_cycles  = 6000;

    // Car state codes above the stop range
    localparam logic [`STATE_BITS-1:0] move_up   = `STATE_BITS'(32);
    localparam logic [`STATE_BITS-1:0] move_down = `STATE_BITS'(33);
    localparam logic [`STATE_BITS-1:0] halted    = `STATE_BITS'(63);

    logic                      clock;
    logic                      reset_n;
    elevator_pkg::button_set_t buttons;
    elevator_pkg::car_status_t car;
    logic                      power_on;
    logic                      emergency;
    logic                      door_open_button;
    logic                      door_close_button;
    elevator_pkg::dispatch_t   dispatch;
    elevator_pkg::button_set_t lights;
    logic                      door_open_allowed;
    logic                      door_close_allowed;

    // Reference model
    int                        model_stack [`FLOOR_COUNT];
    int                        model_count;
    elevator_pkg::button_set_t model_lights;
    elevator_pkg::dispatch_t   expected;

    // Car model and power events
    logic                      moving;
    logic [`FLOOR_BITS-1:0]    goal;
    int                        wait_cycles;
    int                        off_cycles;
    int                        alarm_cycles;

    int                        pops;
    int                        full_refusals;
    int                        clears;

    floor_controller_top dut0 (
        .clock              (clock),
        .reset_n            (reset_n),
        .buttons            (buttons),
        .car                (car),
        .power_on           (power_on),
        .emergency          (emergency),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .dispatch           (dispatch),
        .lights             (lights),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_lights(string name, elevator_pkg::button_set_t exp,
                                elevator_pkg::button_set_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_dispatch(string name, elevator_pkg::dispatch_t exp,
                                  elevator_pkg::dispatch_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_door(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Lowest pressed floor that is unlit and not the car's floor, or -1
    function automatic int first_open(logic [`FLOOR_COUNT-1:0] pressed,
                                      logic [`FLOOR_COUNT-1:0] lit, int here);
        for (int f = 0; f < `FLOOR_COUNT; f++) begin
            if (pressed[f] && !lit[f] && f != here) begin
                return f;
            end
        end
        return -1;
    endfunction

    task automatic check_and_advance(int cyc);
        logic active;
        logic stopped;
        logic pop;
        logic from_panel;
        int   top;
        int   here;
        int   pushed;
        active  = power_on && !emergency;
        stopped = car.state <= `STATE_BITS'(`STOP_STATE_LAST);
        here    = int'(car.floor);
        top     = (model_count > 0) ? model_stack[model_count - 1] : 0;

        expected.activate     = stopped && active && model_count > 0;
        expected.target       = expected.activate ? `FLOOR_BITS'(top) : car.floor;
        expected.direction_up = expected.activate && (top >= here);
        pop = expected.activate && (top == here);

        check_lights($sformatf("lights, cycle %0d", cyc), model_lights, lights);
        check_dispatch($sformatf("dispatch, cycle %0d", cyc), expected, dispatch);
        check_door($sformatf("door open, cycle %0d", cyc),
                   stopped && power_on && door_open_button, door_open_allowed);
        check_door($sformatf("door close, cycle %0d", cyc),
                   stopped && power_on && door_close_button, door_close_allowed);

        // Panel first, then hall calls
        pushed     = first_open(buttons.panel, model_lights.panel, here);
        from_panel = (pushed >= 0);
        if (!from_panel) begin
            pushed = first_open(buttons.call, model_lights.call, here);
        end

        if (!active) begin
            if (model_count > 0 || model_lights != '0) begin
                clears++;
            end
            model_count  = 0;
            model_lights = '0;
        end else begin
            if (pop) begin
                model_lights.call[top]  = 1'b0;
                model_lights.panel[top] = 1'b0;
                pops++;
            end
            if (pushed >= 0 && model_count == `FLOOR_COUNT) begin
                full_refusals++;
            end
            if (pushed >= 0 && model_count < `FLOOR_COUNT) begin
                if (pop) begin
                    model_stack[model_count - 1] = pushed;
                end else begin
                    model_stack[model_count] = pushed;
                    model_count++;
                end
                if (from_panel) begin
                    model_lights.panel[pushed] = 1'b1;
                end else begin
                    model_lights.call[pushed] = 1'b1;
                end
            end else if (pop) begin
                model_count--;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Car model and stimulus
    //////////////////////////////////////////////////////////////////////

    // One floor per few cycles toward the last target offered
    task automatic step_car();
        if (!power_on || emergency) begin
            // Only a moving car drops into the halted code
            if (moving) begin
                car.state = halted;
                moving    = 1'b0;
            end
        end else if (moving) begin
            if (wait_cycles > 0) begin
                wait_cycles--;
            end else begin
                if (goal > car.floor) begin
                    car.floor = car.floor + `FLOOR_BITS'(1);
                end else begin
                    car.floor = car.floor - `FLOOR_BITS'(1);
                end
                if (car.floor == goal) begin
                    moving    = 1'b0;
                    car.state = `STATE_BITS'(car.floor);
                end else begin
                    wait_cycles = 1 + $urandom % 3;
                end
            end
        end else begin
            car.state = `STATE_BITS'(car.floor);
            if (expected.activate && expected.target != car.floor) begin
                moving      = 1'b1;
                goal        = expected.target;
                car.state   = expected.direction_up ? move_up : move_down;
                wait_cycles = 1 + $urandom % 3;
            end
        end
    endtask

    task automatic drive_inputs(int cyc);
        logic [31:0] pressed;
        if (off_cycles > 0) begin
            off_cycles--;
        end else if (alarm_cycles > 0) begin
            alarm_cycles--;
        end else if ($urandom % 400 == 0) begin
            off_cycles = 2 + $urandom % 6;
        end else if ($urandom % 400 == 0) begin
            alarm_cycles = 2 + $urandom % 6;
        end
        power_on  = (off_cycles == 0);
        emergency = (alarm_cycles > 0);

        // Busy phases fill the stack, quiet phases let it drain
        pressed = $urandom;
        repeat (((cyc / 300) % 2 == 1) ? 8 : 2) pressed = pressed & $urandom;
        buttons = elevator_pkg::button_set_t'(pressed[2*`FLOOR_COUNT-1:0]);

        door_open_button  = ($urandom % 4 == 0);
        door_close_button = ($urandom % 4 == 0);
        step_car();
    endtask

    initial begin
        #((reset_cycles + test_cycles + 100) * clock_period);
        $display("Watchdog expired before the test cycles completed");
        $display("Test FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        void'($urandom(32'hc3ae_3f3c));
        reset_n           = 1'b0;
        buttons           = '0;
        car               = '0;
        power_on          = 1'b1;
        emergency         = 1'b0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        model_count       = 0;
        model_lights      = '0;
        expected          = '0;
        moving            = 1'b0;
        goal              = '0;
        wait_cycles       = 0;
        off_cycles        = 0;
        alarm_cycles      = 0;
        pops              = 0;
        full_refusals     = 0;
        clears            = 0;

        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        for (int cyc = 0; cyc < test_cycles; cyc++) begin
            @(negedge clock);
            drive_inputs(cyc);
            #(clock_period / 2 - 1);
            check_and_advance(cyc);
        end

        if (pops == 0 || full_refusals == 0 || clears == 0) begin
            $display("Run missed a behavior: pops %0d, refused pushes %0d, clears %0d",
                     pops, full_refusals, clears);
            $display("Test FAILED");
            $fatal(1, "incomplete run");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+verilog
verilog/elevator_pkg.sv
verilog/request_capture.sv
verilog/floor_request_stack.sv
verilog/dispatch_unit.sv
verilog/floor_controller_top.sv
tests/floor_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the floor controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert -j 0 \
    --top-module floor_controller_tb \
    --Mdir "$BUILD" -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/Vfloor_controller_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
fi

if grep -qx "Test OK" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
